// File: design/vend_pkg.sv
/*
 * Vending machine shared definitions
 * Money and coin widths, coin values, row prices, the selection
 * record, controller states and small helper functions for the
 * coin, selection and change blocks.
 */
package vend_pkg;

    typedef logic [9:0] cents_t;      // Money in cents
    typedef logic [2:0] coin_code_t;  // 0 none, 1..6 coins, 7 rejected
    typedef logic [4:0] item_code_t;  // 0 none, 1..20 items
    typedef logic [1:0] row_t;        // Row A..D
    typedef logic [2:0] col_t;        // Column 1..5

    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 5;

    // Indexed by coin code with code 7 worth nothing
    localparam cents_t COIN_VALUE [8] = '{
        10'd0, 10'd1, 10'd5, 10'd10, 10'd25, 10'd50, 10'd100, 10'd0
    };

    localparam cents_t ROW_PRICE [NUM_ROWS] = '{10'd100, 10'd125, 10'd150, 10'd175};

    typedef struct packed {
        logic valid;
        row_t row;
        col_t col;
    } selection_t;

    typedef enum logic [1:0] {
        ST_COLLECT,
        ST_VEND,
        ST_CHANGE
    } vend_state_t;

    function automatic cents_t coin_value(input coin_code_t code);
        return COIN_VALUE[code];
    endfunction

    function automatic item_code_t item_code(input row_t row, input col_t col);
        return item_code_t'(row * NUM_COLS + col + 1);
    endfunction

    // Values rise with the code, so the last fit is the largest
    function automatic coin_code_t largest_coin(input cents_t amount);
        coin_code_t best;
        best = '0;
        for (int c = 1; c < 7; c++) begin
            if (COIN_VALUE[c] <= amount) begin
                best = coin_code_t'(c);
            end
        end
        return best;
    endfunction

endpackage

// File: design/coin_accumulator.sv
/*
 * Coin accumulator
 * Sums accepted coin values into the credit register, saturating
 * at full scale. A clear pulse empties the credit.
 */
module coin_accumulator (
    input  logic                 clock,
    input  logic                 reset,
    input  vend_pkg::coin_code_t coin_in,
    input  logic                 coin_accept,
    input  logic                 credit_clear,
    output vend_pkg::cents_t     credit
);

    logic [10:0]      sum_wide;  // One extra bit to catch overflow
    vend_pkg::cents_t sum_next;

    assign sum_wide = {1'b0, credit} + {1'b0, vend_pkg::coin_value(coin_in)};

    always_comb begin
        if (sum_wide[10]) begin
            sum_next = '1;  // Saturate at 1023
        end else begin
            sum_next = sum_wide[9:0];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            credit <= '0;
        end else if (credit_clear) begin
            credit <= '0;
        end else if (coin_accept) begin
            credit <= sum_next;  // Codes 0 and 7 add zero
        end
    end

endmodule

// File: design/selection_decoder.sv
/*
 * Selection decoder
 * Encodes the lowest pressed row and column key and holds them as
 * one selection until the controller drops it.
 */
module selection_decoder (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [vend_pkg::NUM_ROWS-1:0]   row_keys,
    input  logic [vend_pkg::NUM_COLS-1:0]   col_keys,
    input  logic                            pick_clear,
    output vend_pkg::selection_t            pick
);

    vend_pkg::row_t row_sel;
    vend_pkg::col_t col_sel;
    logic           key_pair;

    //////////////////////////////
    // Priority encoders
    //////////////////////////////

    // Scan downward so the lowest pressed key wins
    always_comb begin
        row_sel = '0;
        for (int r = vend_pkg::NUM_ROWS - 1; r >= 0; r--) begin
            if (row_keys[r]) begin
                row_sel = vend_pkg::row_t'(r);
            end
        end
    end

    always_comb begin
        col_sel = '0;
        for (int c = vend_pkg::NUM_COLS - 1; c >= 0; c--) begin
            if (col_keys[c]) begin
                col_sel = vend_pkg::col_t'(c);
            end
        end
    end

    assign key_pair = (|row_keys) && (|col_keys);

    //////////////////////////////
    // Held selection
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pick <= '0;
        end else if (pick_clear) begin
            pick <= '0;
        end else if (!pick.valid && key_pair) begin
            pick <= '{valid: 1'b1, row: row_sel, col: col_sel};
        end
    end

endmodule

// File: design/change_dispenser.sv
/*
 * Change dispenser
 * Loads the amount owed, then returns the largest fitting coin each
 * cycle until nothing is left, and pulses done once at the end.
 */
module change_dispenser (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 change_load,
    input  vend_pkg::cents_t     change_amount,
    output vend_pkg::coin_code_t coin_to_return,
    output vend_pkg::cents_t     change_left,
    output logic                 change_done
);

    vend_pkg::coin_code_t next_coin;
    logic                 busy;

    assign next_coin = vend_pkg::largest_coin(change_left);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy           <= 1'b0;
            change_left    <= '0;
            coin_to_return <= '0;
            change_done    <= 1'b0;
        end else if (change_load) begin
            busy           <= 1'b1;
            change_left    <= change_amount;
            coin_to_return <= '0;
            change_done    <= 1'b0;
        end else if (busy) begin
            if (change_left == '0) begin
                busy           <= 1'b0;
                coin_to_return <= '0;
                change_done    <= 1'b1;  // Single cycle
            end else begin
                coin_to_return <= next_coin;
                change_left    <= change_left - vend_pkg::coin_value(next_coin);
            end
        end else begin
            coin_to_return <= '0;
            change_done    <= 1'b0;
        end
    end

endmodule

// File: design/vend_controller.sv
/*
 * Vending controller
 * State machine for collecting coins, checking the selected row's
 * price, holding the item code until the drop is sensed, and
 * starting the change payout. Also picks the display source.
 */
module vend_controller (
    input  logic                  clock,
    input  logic                  reset,
    input  vend_pkg::selection_t  pick,
    input  vend_pkg::cents_t      credit,
    input  logic                  food_dispensed,
    input  logic                  change_done,
    input  vend_pkg::cents_t      change_left,
    output logic                  coin_accept,
    output logic                  credit_clear,
    output logic                  pick_clear,
    output logic                  change_load,
    output vend_pkg::cents_t      change_amount,
    output vend_pkg::item_code_t  food_selection,
    output vend_pkg::cents_t      num_to_display
);

    vend_pkg::vend_state_t state;
    vend_pkg::cents_t      price;
    logic                  check;

    assign price = vend_pkg::ROW_PRICE[pick.row];
    assign check = pick.valid && !pick_clear;  // Skip a pick being dropped

    assign num_to_display = (state == vend_pkg::ST_CHANGE) ? change_left : credit;

    //////////////////////////////
    // State machine
    //////////////////////////////

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state          <= vend_pkg::ST_COLLECT;
            coin_accept    <= 1'b1;
            credit_clear   <= 1'b0;
            pick_clear     <= 1'b0;
            change_load    <= 1'b0;
            food_selection <= '0;
        end else begin
            credit_clear <= 1'b0;  // Pulses
            pick_clear   <= 1'b0;
            change_load  <= 1'b0;
            case (state)
                vend_pkg::ST_COLLECT: begin
                    if (check) begin
                        if (credit >= price) begin
                            food_selection <= vend_pkg::item_code(pick.row, pick.col);
                            coin_accept    <= 1'b0;
                            state          <= vend_pkg::ST_VEND;
                        end else begin
                            pick_clear <= 1'b1;  // Not enough credit
                        end
                    end
                end
                vend_pkg::ST_VEND: begin
                    if (food_dispensed) begin
                        food_selection <= '0;
                        change_load    <= 1'b1;
                        credit_clear   <= 1'b1;
                        state          <= vend_pkg::ST_CHANGE;
                    end
                end
                vend_pkg::ST_CHANGE: begin
                    if (change_done) begin
                        pick_clear  <= 1'b1;  // Release the sold selection
                        coin_accept <= 1'b1;
                        state       <= vend_pkg::ST_COLLECT;
                    end
                end
                default: begin
                    coin_accept <= 1'b1;
                    state       <= vend_pkg::ST_COLLECT;
                end
            endcase
        end
    end

    // Change owed latched with the load pulse
    always_ff @(posedge clock) begin
        if (state == vend_pkg::ST_VEND && food_dispensed) begin
            change_amount <= credit - price;
        end
    end

endmodule

// File: design/vending_machine.sv
/*
 * Vending machine top level
 * Four rows of five items. Connects the coin accumulator,
 * selection decoder, controller and change dispenser.
 */
module vending_machine (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [vend_pkg::NUM_ROWS-1:0]   row_keys,
    input  logic [vend_pkg::NUM_COLS-1:0]   col_keys,
    input  vend_pkg::coin_code_t            coin_in,
    input  logic                            food_dispensed,
    output vend_pkg::cents_t                num_to_display,
    output vend_pkg::item_code_t            food_selection,
    output vend_pkg::coin_code_t            coin_to_return
);

    vend_pkg::selection_t pick;
    vend_pkg::cents_t     credit;
    vend_pkg::cents_t     change_amount;
    vend_pkg::cents_t     change_left;
    logic                 coin_accept;
    logic                 credit_clear;
    logic                 pick_clear;
    logic                 change_load;
    logic                 change_done;

    coin_accumulator accum0 (
        .clock        (clock),
        .reset        (reset),
        .coin_in      (coin_in),
        .coin_accept  (coin_accept),
        .credit_clear (credit_clear),
        .credit       (credit)
    );

    selection_decoder select0 (
        .clock      (clock),
        .reset      (reset),
        .row_keys   (row_keys),
        .col_keys   (col_keys),
        .pick_clear (pick_clear),
        .pick       (pick)
    );

    vend_controller ctrl0 (
        .clock          (clock),
        .reset          (reset),
        .pick           (pick),
        .credit         (credit),
        .food_dispensed (food_dispensed),
        .change_done    (change_done),
        .change_left    (change_left),
        .coin_accept    (coin_accept),
        .credit_clear   (credit_clear),
        .pick_clear     (pick_clear),
        .change_load    (change_load),
        .change_amount  (change_amount),
        .food_selection (food_selection),
        .num_to_display (num_to_display)
    );

    change_dispenser change0 (
        .clock          (clock),
        .reset          (reset),
        .change_load    (change_load),
        .change_amount  (change_amount),
        .coin_to_return (coin_to_return),
        .change_left    (change_left),
        .change_done    (change_done)
    );

endmodule

// File: test/vending_machine_tb.sv
/*
 * Vending machine testbench
 * Drives coins, key pairs and the food sensor, keeps a reference
 * model of credit, item code and change owed, and checks the DUT
 * with concurrent and immediate assertions.
 */
module vending_machine_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLOCK_PERIOD = 20;
    localparam int NUM_TESTS    = 6;
    localparam int CHANGE_LIMIT = 40;  // Cycles for one payout

    logic                          clock;
    logic                          reset;
    logic [vend_pkg::NUM_ROWS-1:0] row_keys;
    logic [vend_pkg::NUM_COLS-1:0] col_keys;
    vend_pkg::coin_code_t          coin_in;
    logic                          food_dispensed;
    vend_pkg::cents_t              num_to_display;
    vend_pkg::item_code_t          food_selection;
    vend_pkg::coin_code_t          coin_to_return;

    vend_pkg::cents_t     exp_credit = '0;
    vend_pkg::item_code_t exp_food   = '0;
    vend_pkg::cents_t     left       = '0;  // Change still owed
    vend_pkg::cents_t     sold_price = '0;
    logic                 accepting  = 1'b1;
    logic                 check_reset = 1'b0;
    logic                 show_credit = 1'b0;
    logic                 paying      = 1'b0;

    integer seed           = 32'h1649c09e;
    string  test_name      = "";
    int     check_fails    = 0;
    int     task_fails     = 0;
    int     fails_at_start = 0;
    int     tests_done     = 0;
    int     tests_failed   = 0;

    vending_machine dut0 (
        .clock          (clock),
        .reset          (reset),
        .row_keys       (row_keys),
        .col_keys       (col_keys),
        .coin_in        (coin_in),
        .food_dispensed (food_dispensed),
        .num_to_display (num_to_display),
        .food_selection (food_selection),
        .coin_to_return (coin_to_return)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(NUM_TESTS * 400 * CLOCK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", NUM_TESTS * 400);
        $display("TEST FAILED");
        $finish;
    end

    // Largest fitting coin searched from the top
    function automatic vend_pkg::coin_code_t biggest_fit(input vend_pkg::cents_t amount);
        for (int c = 6; c >= 1; c--) begin
            if (vend_pkg::COIN_VALUE[c] <= amount) begin
                return vend_pkg::coin_code_t'(c);
            end
        end
        return '0;
    endfunction

    //////////////////////////////
    // Checks
    //////////////////////////////

    reset_outputs: assert property (@(posedge clock)
        check_reset |-> (num_to_display == '0 && food_selection == '0 && coin_to_return == '0))
    else begin
        check_fails++;
        $display("FAIL %s outputs: expected 0/0/0, actual %0d/%0d/%0d", test_name,
                 $sampled(num_to_display), $sampled(food_selection), $sampled(coin_to_return));
    end

    display_tracks_credit: assert property (@(posedge clock) disable iff (reset)
        show_credit |-> num_to_display == exp_credit)
    else begin
        check_fails++;
        $display("FAIL %s display: expected %0d, actual %0d", test_name,
                 $sampled(exp_credit), $sampled(num_to_display));
    end

    item_tracks_model: assert property (@(posedge clock) disable iff (reset)
        food_selection == exp_food)
    else begin
        check_fails++;
        $display("FAIL %s item: expected %0d, actual %0d", test_name,
                 $sampled(exp_food), $sampled(food_selection));
    end

    greedy_coin: assert property (@(posedge clock) disable iff (reset)
        (paying && coin_to_return != '0) |-> coin_to_return == biggest_fit(left))
    else begin
        check_fails++;
        $display("FAIL %s coin: expected %0d, actual %0d", test_name,
                 biggest_fit($sampled(left)), $sampled(coin_to_return));
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    task automatic start_test(input string name);
        test_name      = name;
        fails_at_start = check_fails + task_fails;
    endtask

    task automatic finish_test();
        int fails;
        @(posedge clock);
        #1;
        fails = check_fails + task_fails - fails_at_start;
        tests_done++;
        if (fails == 0) begin
            $display("%s: ok", test_name);
        end else begin
            tests_failed++;
            $display("%s: %0d check(s) failed", test_name, fails);
        end
    endtask

    task automatic insert_coin(input vend_pkg::coin_code_t code);
        logic [10:0] sum;
        @(posedge clock);
        coin_in <= code;
        @(posedge clock);  // Coin sampled here
        coin_in <= '0;
        if (accepting) begin
            sum = {1'b0, exp_credit} + {1'b0, vend_pkg::COIN_VALUE[code]};
            if (sum > 11'd1023) begin
                exp_credit = '1;
            end else begin
                exp_credit = sum[9:0];
            end
        end
    endtask

    task automatic press_keys(input int row, input int col);
        logic [vend_pkg::NUM_ROWS-1:0] extra_rows;
        logic [vend_pkg::NUM_COLS-1:0] extra_cols;
        extra_rows = 4'($random(seed));  // Higher keys held as well
        extra_cols = 5'($random(seed));
        @(posedge clock);
        row_keys <= (4'b0001 << row) | (extra_rows & ~((4'b0010 << row) - 4'b0001));
        col_keys <= (5'b00001 << col) | (extra_cols & ~((5'b00010 << col) - 5'b00001));
        @(posedge clock);  // Pick registered
        row_keys <= '0;
        col_keys <= '0;
        @(posedge clock);  // Price check
        if (exp_credit >= vend_pkg::ROW_PRICE[row]) begin
            exp_food   = vend_pkg::item_code_t'(row * 5 + col + 1);
            sold_price = vend_pkg::ROW_PRICE[row];
            accepting  = 1'b0;
        end
    endtask

    task automatic dispense();
        vend_pkg::cents_t change_due;
        vend_pkg::cents_t returned;
        int               waited;
        @(posedge clock);
        food_dispensed <= 1'b1;
        @(posedge clock);  // Sensor sampled
        food_dispensed <= 1'b0;
        change_due  = exp_credit - sold_price;
        left        = change_due;
        returned    = '0;
        exp_food    = '0;
        exp_credit  = '0;
        show_credit = 1'b0;  // Display shows change left
        paying      = 1'b1;
        waited      = 0;
        do begin
            @(posedge clock);
            if (coin_to_return != '0) begin
                left     = left - vend_pkg::COIN_VALUE[coin_to_return];
                returned = returned + vend_pkg::COIN_VALUE[coin_to_return];
            end
            waited++;
        end while (!dut0.change_done && waited < CHANGE_LIMIT);
        if (!dut0.change_done) begin
            task_fails++;
            $display("%s: change payout did not finish within %0d cycles",
                     test_name, CHANGE_LIMIT);
        end
        paying      = 1'b0;
        show_credit = 1'b1;
        accepting   = 1'b1;
        change_sum: assert (returned == change_due) else begin
            task_fails++;
            $display("FAIL %s change sum: expected %0d, actual %0d",
                     test_name, change_due, returned);
        end
        coin_idle: assert (coin_to_return == '0) else begin
            task_fails++;
            $display("FAIL %s idle coin: expected 0, actual %0d", test_name, coin_to_return);
        end
    endtask

    task automatic run_row(input int row);
        int col;
        start_test($sformatf("vend row %c", 65 + row));
        col = $unsigned($random(seed)) % 5;
        press_keys(row, col);  // Credit below price
        while (exp_credit < vend_pkg::ROW_PRICE[row]) begin
            insert_coin(vend_pkg::coin_code_t'(1 + $unsigned($random(seed)) % 6));
        end
        col = $unsigned($random(seed)) % 5;
        press_keys(row, col);
        repeat (3) begin
            insert_coin(vend_pkg::coin_code_t'(1 + $unsigned($random(seed)) % 6));
        end
        dispense();
        insert_coin(3'd3);
        finish_test();
    endtask

    initial begin
        reset          = 1'b1;
        row_keys       = '0;
        col_keys       = '0;
        coin_in        = '0;
        food_dispensed = 1'b0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        start_test("reset");
        @(posedge clock);
        check_reset = 1'b1;
        show_credit = 1'b1;
        @(posedge clock);
        check_reset = 1'b0;
        finish_test();

        for (int row = 0; row < vend_pkg::NUM_ROWS; row++) begin
            run_row(row);
        end

        start_test("credit");
        insert_coin(3'd7);
        insert_coin(3'd0);
        repeat (14) begin
            insert_coin(vend_pkg::coin_code_t'($unsigned($random(seed)) % 8));
        end
        finish_test();

        $display("%0d tests run, %0d failed, %0d failed checks",
                 tests_done, tests_failed, check_fails + task_fails);
        if (tests_failed == 0 && check_fails + task_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
design/vend_pkg.sv
design/coin_accumulator.sv
design/selection_decoder.sv
design/change_dispenser.sv
design/vend_controller.sv
design/vending_machine.sv
test/vending_machine_tb.sv

// File: Makefile
# Verilator build, run and lint for the vending machine

VERILATOR  ?= verilator
TOP        ?= vending_machine_tb
RTL_TOP    ?= vending_machine
FILELIST   ?= files.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
FLAGS      ?= --binary --timing --assert --timescale 1ns/100ps
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
